// File: Makefile
# Verilator simulation of the collective instruction stage

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = reduce_instr_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails on a nonzero exit or when the log holds the fail message
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/coll_cfg.svh
`ifndef COLL_CFG_SVH
`define COLL_CFG_SVH

//////////////////////////////////////////////////////////////////////
// flit geometry
//////////////////////////////////////////////////////////////////////

`define FLIT_W       82  // input flit
`define FLIT_OUT_W   85  // flit plus children count
`define CHILD_W      3   // children field on top of the flit

// field widths, top bit down
`define COORD_W      3   // one mesh axis
`define RANK_W       9   // rank and node address
`define CTX_W        8   // communicator context id
`define TAG_W        8
`define ALG_W        2
`define OP_W         4
`define PAYLOAD_W    32

// valid bit sits at the top of the bare flit
`define VALID_POS    81

//////////////////////////////////////////////////////////////////////
// communicator and machine size
//////////////////////////////////////////////////////////////////////

`define COMM_SIZE    4   // table entries
`define LG_NUMPROCS  3
`define NUM_PROCS    8

//////////////////////////////////////////////////////////////////////
// default node placement, z/y/x packed
//////////////////////////////////////////////////////////////////////

`define DEF_LOCAL_COORD  9'b000_000_000
`define DEF_ROOT_COORD   9'b001_001_001
`define DEF_CUR_RANK     9'd0
`define DEF_ROOT_RANK    9'd0

`endif

// File: design/coll_pkg.sv
`default_nettype none

package coll_pkg;

	`include "coll_cfg.svh"

	//////////////////////////////////////////////////////////////////////
	// addresses and ranks
	//////////////////////////////////////////////////////////////////////

	typedef logic [`COORD_W-1:0] axis_t;

	// node address, z on top
	typedef struct packed {
		axis_t z;
		axis_t y;
		axis_t x;
	} coord_t;

	typedef logic [`RANK_W-1:0] rank_t;

	// only the routed opcodes get names, the rest take the default path
	typedef enum logic [`OP_W-1:0] {
		OP_NONE           = 4'b0000,
		OP_RING_ALLGATHER = 4'b1001, // long allgather, ring
		OP_GATHER         = 4'b1011, // uptree
		OP_BARRIER        = 4'b1100  // uptree
	} op_e;

	//////////////////////////////////////////////////////////////////////
	// flits
	//////////////////////////////////////////////////////////////////////

	// 82 bits, bit 81 is valid
	typedef struct packed {
		logic                  valid;
		coord_t                dst;        // 80:72
		coord_t                src;        // 71:63
		rank_t                 rank;       // 62:54
		logic [`CTX_W-1:0]     context_id; // 53:46
		logic [`TAG_W-1:0]     tag;        // 45:38
		logic [`ALG_W-1:0]     algtype;    // 37:36
		op_e                   op;         // 35:32
		logic [`PAYLOAD_W-1:0] payload;    // 31:0
	} flit_t;

	// registered flit with children count, 85 bits
	typedef struct packed {
		logic [`CHILD_W-1:0] children;
		flit_t               flit;
	} flit_out_t;

	//////////////////////////////////////////////////////////////////////
	// communicator table entry, 27 bits
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		rank_t  local_rank; // this node's rank in the communicator
		coord_t successor;  // next node on the ring
		coord_t parent;     // uptree neighbour
	} comm_entry_t;

endpackage

`default_nettype wire

// File: design/comm_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_cfg.svh"

// communicator table read, context in, entry fields out
interface comm_lookup_if;

	logic [`CTX_W-1:0] ctx;        // from the incoming flit
	coll_pkg::rank_t   local_rank;
	coll_pkg::coord_t  parent;
	coll_pkg::coord_t  successor;

	modport tbl     (input ctx, output local_rank, output parent, output successor);

	// rewrite stage supplies the context and wants the local rank
	modport rewrite (output ctx, input local_rank);

	// route stage only looks at neighbours
	modport route   (input parent, input successor);

endinterface

`default_nettype wire

// File: design/comm_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_cfg.svh"

module comm_table (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  cfg_we,      // config write strobe
	input  wire logic [`CTX_W-1:0]     cfg_context, // entry to load
	input  wire coll_pkg::comm_entry_t cfg_entry,
	comm_lookup_if.tbl                 lookup
);

	import coll_pkg::*;

	localparam int IDX_W = $clog2(`COMM_SIZE);
	localparam logic [`CTX_W-1:0] CTX_LIMIT = `CTX_W'(`COMM_SIZE); // first invalid context

	comm_entry_t entries [`COMM_SIZE]; // one per communicator
	comm_entry_t rd_entry;
	logic        wr_ok;

	//////////////////////////////////////////////////////////////////////
	// configuration write
	//////////////////////////////////////////////////////////////////////

	assign wr_ok = cfg_we && (cfg_context < CTX_LIMIT); // out-of-range writes dropped

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `COMM_SIZE; i++) begin
				entries[i] <= '0;
			end
		end else if (wr_ok) begin
			entries[cfg_context[IDX_W-1:0]] <= cfg_entry; // visible next cycle
		end
	end

	//////////////////////////////////////////////////////////////////////
	// combinational lookup
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (lookup.ctx < CTX_LIMIT)
			rd_entry = entries[lookup.ctx[IDX_W-1:0]];
		else
			rd_entry = '0; // unknown communicator reads as empty
	end

	assign lookup.local_rank = rd_entry.local_rank;
	assign lookup.parent     = rd_entry.parent;
	assign lookup.successor  = rd_entry.successor;

	// host must not load the table while the node is held in reset
	a_no_cfg_in_reset: assert property (@(posedge clk) !(rst && cfg_we))
		else $error("comm_table: cfg_we asserted during rst");

endmodule

`default_nettype wire

// File: design/flit_rewrite.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_cfg.svh"

module flit_rewrite #(
	parameter coll_pkg::coord_t local_coord = `DEF_LOCAL_COORD,
	parameter coll_pkg::coord_t root_coord  = `DEF_ROOT_COORD
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire coll_pkg::flit_t     packet_in,
	comm_lookup_if.rewrite           lookup,
	output coll_pkg::flit_out_t      packet_out
);

	import coll_pkg::*;

	localparam logic [`CHILD_W-1:0] CHILD_ALL  = `CHILD_W'(`NUM_PROCS - 1);
	localparam logic [`CHILD_W-1:0] CHILD_ROOT = `CHILD_W'(`LG_NUMPROCS);

	// idle slot, empty flit but children still at full count
	localparam flit_out_t IDLE_OUT = '{children: CHILD_ALL, flit: '0};

	logic      redirect;  // collective aimed at this node
	logic      self_addr; // flit sent to its own source
	flit_out_t next_out;

	assign lookup.ctx = packet_in.context_id; // table indexed by incoming flit

	//////////////////////////////////////////////////////////////////////
	// field rewrite
	//////////////////////////////////////////////////////////////////////

	assign redirect  = packet_in.valid
		&& (packet_in.dst == local_coord)
		&& (packet_in.op != OP_NONE);
	assign self_addr = (packet_in.dst == packet_in.src);

	always_comb begin
		next_out.flit = packet_in; // everything copied by default

		// turn it toward the root
		if (redirect) begin
			next_out.flit.dst = root_coord;
			next_out.children = CHILD_ROOT;
		end else begin
			next_out.children = CHILD_ALL;
		end

		if (self_addr)
			next_out.flit.rank = lookup.local_rank; // substitute communicator rank
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || !packet_in.valid)
			packet_out <= IDLE_OUT; // bubble
		else
			packet_out <= next_out;
	end

	// a valid flit out needs a valid flit in one cycle earlier
	a_valid_follows_in: assert property (
		@(posedge clk) disable iff (rst)
		packet_out[`VALID_POS] |-> $past(packet_in.valid)
	) else $error("flit_rewrite: valid output without valid input");

endmodule

`default_nettype wire

// File: design/reduce_instr.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_cfg.svh"

module reduce_instr #(
	parameter coll_pkg::coord_t local_coord = `DEF_LOCAL_COORD,
	parameter coll_pkg::coord_t root_coord  = `DEF_ROOT_COORD,
	parameter coll_pkg::rank_t  cur_rank    = `DEF_CUR_RANK,
	parameter coll_pkg::rank_t  root_rank   = `DEF_ROOT_RANK
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire coll_pkg::flit_t     packet_in,
	// communicator table load
	input  wire logic                cfg_we,
	input  wire logic [`CTX_W-1:0]   cfg_context,
	input  wire coll_pkg::rank_t     cfg_local_rank,
	input  wire coll_pkg::coord_t    cfg_parent,
	input  wire coll_pkg::coord_t    cfg_successor,
	// stage outputs
	output coll_pkg::flit_out_t      packet_out,
	output coll_pkg::coord_t         next_dst,
	output logic                     rd_en
);

	import coll_pkg::*;

	comm_entry_t cfg_entry;

	assign cfg_entry = '{
		local_rank: cfg_local_rank,
		successor:  cfg_successor,
		parent:     cfg_parent
	};

	comm_lookup_if lookup_if ();

	comm_table comm_table_inst (
		.clk         (clk),
		.rst         (rst),
		.cfg_we      (cfg_we),
		.cfg_context (cfg_context),
		.cfg_entry   (cfg_entry),
		.lookup      (lookup_if.tbl)
	);

	flit_rewrite #(.local_coord(local_coord), .root_coord(root_coord)) flit_rewrite_inst (
		.clk        (clk),
		.rst        (rst),
		.packet_in  (packet_in),
		.lookup     (lookup_if.rewrite),
		.packet_out (packet_out)
	);

	route_select #(
		.local_coord (local_coord),
		.root_coord  (root_coord),
		.cur_rank    (cur_rank),
		.root_rank   (root_rank)
	) route_select_inst (
		.clk       (clk),
		.rst       (rst),
		.packet_in (packet_in),
		.lookup    (lookup_if.route),
		.next_dst  (next_dst),
		.rd_en     (rd_en)
	);

endmodule

`default_nettype wire

// File: design/route_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_cfg.svh"

module route_select #(
	parameter coll_pkg::coord_t local_coord = `DEF_LOCAL_COORD,
	parameter coll_pkg::coord_t root_coord  = `DEF_ROOT_COORD,
	parameter coll_pkg::rank_t  cur_rank    = `DEF_CUR_RANK,
	parameter coll_pkg::rank_t  root_rank   = `DEF_ROOT_RANK
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire coll_pkg::flit_t packet_in,
	comm_lookup_if.route         lookup,
	output coll_pkg::coord_t     next_dst,  // next hop
	output logic                 rd_en      // consume the flit here
);

	import coll_pkg::*;

	localparam rank_t LAST_RANK = rank_t'(`NUM_PROCS - 1); // ring tail

	logic   from_guest; // flit injected elsewhere
	logic   ring_home;  // ring flit has come back around
	coord_t ring_dst;
	logic   ring_rd;
	coord_t uptree_dst;
	coord_t sel_dst;
	logic   sel_rd;

	assign from_guest = (packet_in.src != local_coord);

	//////////////////////////////////////////////////////////////////////
	// ring, long allgather
	//////////////////////////////////////////////////////////////////////

	// one-cycle pulse after a guest ring flit arrives
	always_ff @(posedge clk) begin
		if (rst)
			ring_home <= 1'b0;
		else
			ring_home <= packet_in.valid
				&& from_guest
				&& !ring_home
				&& (packet_in.op == OP_RING_ALLGATHER);
	end

	always_comb begin
		if (ring_home)
			ring_dst = local_coord;       // keep it here
		else if (cur_rank == LAST_RANK)
			ring_dst = root_coord;        // tail wraps to root
		else
			ring_dst = lookup.successor;
	end

	assign ring_rd = ring_home || !from_guest; // own flits always read

	//////////////////////////////////////////////////////////////////////
	// uptree, gather and barrier
	//////////////////////////////////////////////////////////////////////

	assign uptree_dst = (cur_rank == root_rank) ? local_coord : lookup.parent;

	//////////////////////////////////////////////////////////////////////
	// opcode select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (packet_in.op)
			OP_RING_ALLGATHER: begin
				sel_dst = ring_dst;
				sel_rd  = ring_rd;
			end
			OP_GATHER,
			OP_BARRIER: begin
				sel_dst = uptree_dst;
				sel_rd  = 1'b1;
			end
			default: begin
				sel_dst = root_coord; // dropped algorithms and idle
				sel_rd  = 1'b1;
			end
		endcase
	end

	// registered every cycle, no valid qualifier
	always_ff @(posedge clk) begin
		if (rst) begin
			next_dst <= '0;
			rd_en    <= 1'b0;
		end else begin
			next_dst <= sel_dst;
			rd_en    <= sel_rd;
		end
	end

	// home pulse never stretches, a second ring flit must go out again
	a_ring_home_pulse: assert property (
		@(posedge clk) disable iff (rst)
		ring_home |=> !ring_home
	) else $error("route_select: ring_home high two cycles in a row");

endmodule

`default_nettype wire

// File: verif/reduce_instr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_cfg.svh"

module reduce_instr_tb;

	import coll_pkg::*;

	localparam int CLK_PERIOD   = 4;   // ns
	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES  = 48;  // reset plus all directed tests, rounded up
	localparam int MARGIN       = 100; // ns of slack for the watchdog

	// node placement, octal digits are z/y/x
	localparam coord_t LOCAL_COORD = coord_t'(9'o000);
	localparam coord_t ROOT_COORD  = coord_t'(9'o111);
	localparam rank_t  CUR_RANK    = rank_t'(3);
	localparam rank_t  ROOT_RANK   = rank_t'(0);

	localparam coord_t REMOTE_A = coord_t'(9'o231);
	localparam coord_t REMOTE_B = coord_t'(9'o102);

	// children counts for an 8 node machine
	localparam logic [`CHILD_W-1:0] CHILD_ALL  = 3'd7; // every other node
	localparam logic [`CHILD_W-1:0] CHILD_ROOT = 3'd3; // log2 of 8

	logic              clk;
	logic              rst;
	flit_t             packet_in;
	logic              cfg_we;
	logic [`CTX_W-1:0] cfg_context;
	rank_t             cfg_local_rank;
	coord_t            cfg_parent;
	coord_t            cfg_successor;
	flit_out_t         packet_out;
	coord_t            next_dst;
	logic              rd_en;

	int errors; // failed checks
	int checks; // checks run

	reduce_instr #(
		.local_coord (LOCAL_COORD),
		.root_coord  (ROOT_COORD),
		.cur_rank    (CUR_RANK),
		.root_rank   (ROOT_RANK)
	) reduce_instr_inst (
		.clk            (clk),
		.rst            (rst),
		.packet_in      (packet_in),
		.cfg_we         (cfg_we),
		.cfg_context    (cfg_context),
		.cfg_local_rank (cfg_local_rank),
		.cfg_parent     (cfg_parent),
		.cfg_successor  (cfg_successor),
		.packet_out     (packet_out),
		.next_dst       (next_dst),
		.rd_en          (rd_en)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// edge, then 1 ns, where inputs change and outputs are read
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic flit_t make_flit(input coord_t dst, input coord_t src, input rank_t rank,
		input logic [`CTX_W-1:0] ctx, input logic [`OP_W-1:0] op);
		flit_t f;
		f.valid      = 1'b1;
		f.dst        = dst;
		f.src        = src;
		f.rank       = rank;
		f.context_id = ctx;
		f.tag        = `TAG_W'($urandom); // random filler
		f.algtype    = `ALG_W'($urandom);
		f.op         = op_e'(op);         // dropped opcodes too
		f.payload    = $urandom;
		return f;
	endfunction

	task automatic write_table(input logic [`CTX_W-1:0] ctx, input rank_t rank,
		input coord_t parent, input coord_t succ);
		cfg_we         = 1'b1;
		cfg_context    = ctx;
		cfg_local_rank = rank;
		cfg_parent     = parent;
		cfg_successor  = succ;
		next_cycle(); // entry readable from here on
		cfg_we         = 1'b0;
	endtask

	// one flit in, outputs for it readable on return
	task automatic send(input flit_t f);
		packet_in = f;
		next_cycle();
	endtask

	task automatic idle();
		packet_in = '0;
		next_cycle();
	endtask

	task automatic check_flit(input string name, input flit_out_t exp);
		checks++;
		assert (packet_out === exp) else begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, exp, packet_out);
		end
	endtask

	task automatic check_route(input string name, input coord_t exp_dst, input logic exp_rd);
		checks++;
		assert (next_dst === exp_dst && rd_en === exp_rd) else begin
			errors++;
			$display("ERR %s: expected dst %h rd_en %b, actual dst %h rd_en %b",
				name, exp_dst, exp_rd, next_dst, rd_en);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		flit_t f;
		check_flit("test_reset_idle", '{children: CHILD_ALL, flit: '0}); // still in reset
		check_route("test_reset_idle", '0, 1'b0);
		rst = 1'b0;
		f = make_flit(REMOTE_A, REMOTE_B, rank_t'(9), 8'd0, OP_NONE);
		f.valid = 1'b0; // bubble with junk fields
		send(f);
		check_flit("test_reset_idle", '{children: CHILD_ALL, flit: '0});
		check_route("test_reset_idle", ROOT_COORD, 1'b1); // op 0 takes default
	endtask

	task automatic test_passthrough();
		flit_t f;
		f = make_flit(REMOTE_A, REMOTE_B, rank_t'(17), 8'd1, OP_BARRIER);
		send(f);
		check_flit("test_passthrough", '{children: CHILD_ALL, flit: f});
		f = make_flit(REMOTE_B, REMOTE_A, rank_t'(255), 8'd3, OP_NONE);
		send(f); // back to back
		check_flit("test_passthrough", '{children: CHILD_ALL, flit: f});
		idle();
	endtask

	task automatic test_local_redirect();
		flit_t     f;
		flit_out_t exp;
		write_table(8'd2, rank_t'(5), REMOTE_A, REMOTE_B);
		f = make_flit(LOCAL_COORD, REMOTE_A, rank_t'(40), 8'd2, OP_GATHER);
		send(f);
		exp = '{children: CHILD_ROOT, flit: f};
		exp.flit.dst = ROOT_COORD; // turned to root, rank kept
		check_flit("test_local_redirect", exp);
		f = make_flit(LOCAL_COORD, LOCAL_COORD, rank_t'(40), 8'd2, OP_BARRIER);
		send(f);
		exp = '{children: CHILD_ROOT, flit: f};
		exp.flit.dst  = ROOT_COORD;
		exp.flit.rank = rank_t'(5); // self addressed, table rank
		check_flit("test_local_redirect", exp);
		f = make_flit(LOCAL_COORD, REMOTE_B, rank_t'(40), 8'd2, OP_NONE);
		send(f);
		check_flit("test_local_redirect", '{children: CHILD_ALL, flit: f}); // op 0 not redirected
		idle();
	endtask

	task automatic test_uptree();
		write_table(8'd1, rank_t'(2), coord_t'(9'o210), coord_t'(9'o013));
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(1), 8'd1, OP_GATHER));
		check_route("test_uptree", coord_t'(9'o210), 1'b1); // cur_rank is not root
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(1), 8'd1, OP_BARRIER));
		check_route("test_uptree", coord_t'(9'o210), 1'b1);
		idle();
	endtask

	task automatic test_ring();
		write_table(8'd3, rank_t'(6), REMOTE_B, coord_t'(9'o321));
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(4), 8'd3, OP_RING_ALLGATHER));
		check_route("test_ring", coord_t'(9'o321), 1'b0); // guest goes on to successor
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(4), 8'd3, OP_RING_ALLGATHER));
		check_route("test_ring", LOCAL_COORD, 1'b1);       // home pulse keeps it here
		send(make_flit(REMOTE_A, LOCAL_COORD, rank_t'(4), 8'd3, OP_RING_ALLGATHER));
		check_route("test_ring", coord_t'(9'o321), 1'b1); // own flit, read it
		idle();
	endtask

	task automatic test_default_op();
		// entry 0 shares its low index bits with contexts 4 and 200
		write_table(8'd0, rank_t'(1), coord_t'(9'o123), coord_t'(9'o321));
		write_table(8'd4, rank_t'(7), REMOTE_A, REMOTE_A); // out of range, dropped
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(1), 8'd1, 4'b0111));
		check_route("test_default_op", ROOT_COORD, 1'b1);
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(1), 8'd0, OP_GATHER));
		check_route("test_default_op", coord_t'(9'o123), 1'b1); // entry 0 untouched
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(1), 8'd4, OP_GATHER));
		check_route("test_default_op", '0, 1'b1); // empty entry
		send(make_flit(REMOTE_A, REMOTE_B, rank_t'(1), 8'd200, OP_GATHER));
		check_route("test_default_op", '0, 1'b1);
		idle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(64));
		errors         = 0;
		checks         = 0;
		rst            = 1'b1;
		packet_in      = '0;
		cfg_we         = 1'b0;
		cfg_context    = '0;
		cfg_local_rank = '0;
		cfg_parent     = '0;
		cfg_successor  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		test_reset_idle(); // releases rst
		test_passthrough();
		test_local_redirect();
		test_uptree();
		test_ring();
		test_default_op();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD + MARGIN);
		$display("watchdog: tests did not finish in %0d ns", TEST_CYCLES * CLK_PERIOD + MARGIN);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/coll_pkg.sv
design/comm_lookup_if.sv
design/comm_table.sv
design/flit_rewrite.sv
design/route_select.sv
design/reduce_instr.sv
verif/reduce_instr_tb.sv
